// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = tb_zipdbg
FILELIST  = compile.f
LOG       = sim.log
FAIL_MSG  = Checks failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
		if grep -q "$(FAIL_MSG)" $(LOG) || [ $$rc -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+verilog
verilog/zipdbg_pkg.sv
verilog/dbg_skid.sv
verilog/dbg_request.sv
verilog/cpu_control.sv
verilog/dbg_regfile.sv
verilog/dbg_response.sv
verilog/zipdbg_top.sv
tests/tb_zipdbg.sv

// ==== tests/tb_zipdbg.sv ====
////////////////////////////////////////////////////////////
// Testbench of the debug port, run from the project root.
// Stimulus and expected read data come from the stim file.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_zipdbg
	import zipdbg_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int STIM_LINES = 64;
	localparam int STIM_COLS = 6;
	localparam int RANDOM_STALL = 255;

	logic		aclk, aresetn, interrupt, cpu_reset;
	logic		aw_valid, aw_ready, w_valid, w_ready;
	logic [7:0]	aw_addr, ar_addr;
	logic [2:0]	aw_prot, ar_prot;
	dbg_word_t	w_data, r_data;
	dbg_strb_t	w_strb;
	logic		b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready;
	logic [1:0]	b_resp, r_resp;
	logic		cmd_reset, halted;

	// Six hex words per stimulus line
	logic [31:0]	stim [STIM_LINES*STIM_COLS];

	// Outstanding responses, in issue order
	int		b_stall_q[$];
	int		r_stall_q[$];
	dbg_word_t	r_exp_q[$];

	int		errors = 0;
	int		tests_run = 0;
	int		reset_rises = 0;
	int		rises_checked = 0;
	bit		hung = 1'b0;

	zipdbg_top u_dut (
		.S_AXI_ACLK(aclk), .S_AXI_ARESETN(aresetn),
		.i_interrupt(interrupt), .i_cpu_reset(cpu_reset),
		.S_DBG_AWVALID(aw_valid), .S_DBG_AWREADY(aw_ready),
		.S_DBG_AWADDR(aw_addr), .S_DBG_AWPROT(aw_prot),
		.S_DBG_WVALID(w_valid), .S_DBG_WREADY(w_ready),
		.S_DBG_WDATA(w_data), .S_DBG_WSTRB(w_strb),
		.S_DBG_BVALID(b_valid), .S_DBG_BREADY(b_ready), .S_DBG_BRESP(b_resp),
		.S_DBG_ARVALID(ar_valid), .S_DBG_ARREADY(ar_ready),
		.S_DBG_ARADDR(ar_addr), .S_DBG_ARPROT(ar_prot),
		.S_DBG_RVALID(r_valid), .S_DBG_RREADY(r_ready),
		.S_DBG_RDATA(r_data), .S_DBG_RRESP(r_resp),
		.o_cmd_reset(cmd_reset), .o_halted(halted)
	);

	initial
	begin
		aclk = 1'b0;
		forever
			#5 aclk = ~aclk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input dbg_word_t got, input dbg_word_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s response is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		errors++;
		hung = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Response side, ready held low for the queued stall count
	////////////////////////////////////////////////////////////
	initial
	begin : b_watch
		int stalled;
		stalled = 0;
		b_ready = 1'b0;
		forever
		begin
			@(negedge aclk);
			// Handshake completes on the coming edge
			if (b_valid === 1'b1 && b_ready)
			begin
				if (b_stall_q.size() == 0)
				begin
					$display("Write response at %0t with no write outstanding", $time);
					errors++;
				end
				else
					void'(b_stall_q.pop_front());
				check_resp(b_resp, 2'b00, "write");
				stalled = 0;
			end
			else if (b_valid === 1'b1)
				stalled++;
			@(posedge aclk);
			#1;
			if (b_stall_q.size() != 0)
				b_ready = (stalled >= b_stall_q[0]);
			else
				b_ready = 1'b0;
		end
	end

	initial
	begin : r_watch
		int stalled;
		stalled = 0;
		r_ready = 1'b0;
		forever
		begin
			@(negedge aclk);
			if (r_valid === 1'b1 && r_ready)
			begin
				if (r_exp_q.size() == 0)
				begin
					$display("Read response at %0t with no read outstanding", $time);
					errors++;
				end
				else
				begin
					check_word(r_data, r_exp_q.pop_front(), "read data");
					void'(r_stall_q.pop_front());
				end
				check_resp(r_resp, 2'b00, "read");
				stalled = 0;
			end
			else if (r_valid === 1'b1)
				stalled++;
			@(posedge aclk);
			#1;
			if (r_stall_q.size() != 0)
				r_ready = (stalled >= r_stall_q[0]);
			else
				r_ready = 1'b0;
		end
	end

	// Counts rising edges of the CPU reset
	initial
	begin : reset_watch
		logic prev;
		prev = 1'b0;
		forever
		begin
			@(negedge aclk);
			if (cmd_reset === 1'b1 && prev !== 1'b1)
				reset_rises++;
			prev = cmd_reset;
		end
	end

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////
	task automatic send_write(input logic [7:0] addr, input dbg_word_t data,
			input dbg_strb_t strb, input int stall);
		bit aw_done;
		bit w_done;
		int cycles;
		b_stall_q.push_back(stall);
		aw_addr = addr;
		w_data = data;
		w_strb = strb;
		aw_valid = 1'b1;
		w_valid = 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		cycles = 0;
		while (!(aw_done && w_done) && cycles < TIMEOUT)
		begin
			@(negedge aclk);
			if (aw_valid && aw_ready)
				aw_done = 1'b1;
			if (w_valid && w_ready)
				w_done = 1'b1;
			@(posedge aclk);
			#1;
			if (aw_done)
				aw_valid = 1'b0;
			if (w_done)
				w_valid = 1'b0;
			cycles++;
		end
		if (!(aw_done && w_done))
			note_timeout("AWREADY and WREADY");
	endtask

	task automatic send_read(input logic [7:0] addr, input dbg_word_t exp, input int stall);
		bit ar_done;
		int cycles;
		r_stall_q.push_back(stall);
		r_exp_q.push_back(exp);
		ar_addr = addr;
		ar_valid = 1'b1;
		ar_done = 1'b0;
		cycles = 0;
		while (!ar_done && cycles < TIMEOUT)
		begin
			@(negedge aclk);
			ar_done = ar_ready;
			@(posedge aclk);
			#1;
			cycles++;
		end
		ar_valid = 1'b0;
		if (!ar_done)
			note_timeout("ARREADY");
	endtask

	// Every issued transaction answered
	task automatic drain_responses();
		int cycles;
		cycles = 0;
		while ((b_stall_q.size() != 0 || r_stall_q.size() != 0) && cycles < TIMEOUT)
		begin
			@(posedge aclk);
			#1;
			cycles++;
		end
		if (b_stall_q.size() != 0 || r_stall_q.size() != 0)
			note_timeout("BVALID or RVALID");
	endtask

	// A new rise since the last check, then low again
	task automatic wait_reset_pulse();
		int cycles;
		cycles = 0;
		while ((reset_rises == rises_checked || cmd_reset !== 1'b0) && cycles < TIMEOUT)
		begin
			@(posedge aclk);
			#1;
			cycles++;
		end
		if (reset_rises == rises_checked)
			note_timeout("o_cmd_reset to rise");
		else if (cmd_reset !== 1'b0)
			note_timeout("o_cmd_reset to fall");
		rises_checked = reset_rises;
	endtask

	task automatic wait_halted(input logic level);
		int cycles;
		cycles = 0;
		while (halted !== level && cycles < TIMEOUT)
		begin
			@(posedge aclk);
			#1;
			cycles++;
		end
		if (halted !== level)
			note_timeout("o_halted to change");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin : main
		int		line;
		int		base;
		int		op;
		int		stall;
		int		test_start;
		bit		done;
		logic [7:0]	addr;
		dbg_word_t	data;
		dbg_word_t	exp_word;
		dbg_strb_t	strb;

		void'($urandom(32));
		aresetn = 1'b0;
		interrupt = 1'b0;
		cpu_reset = 1'b0;
		aw_valid = 1'b0;
		aw_addr = '0;
		aw_prot = '0;
		w_valid = 1'b0;
		w_data = '0;
		w_strb = '0;
		ar_valid = 1'b0;
		ar_addr = '0;
		ar_prot = '0;
		for (int i = 0; i < STIM_LINES*STIM_COLS; i++)
			stim[i] = '0;
		$readmemh("tests/zipdbg_stim.txt", stim);

		repeat (16) @(posedge aclk);
		#1;
		aresetn = 1'b1;

		// Power-up hold still active
		@(negedge aclk);
		check_bit(cmd_reset, 1'b1, "o_cmd_reset after reset");
		check_bit(b_valid, 1'b0, "BVALID after reset");
		check_bit(r_valid, 1'b0, "RVALID after reset");
		check_bit(halted, 1'b0, "o_halted after reset");
		@(posedge aclk);
		#1;

		test_start = errors;
		line = 0;
		done = 1'b0;
		while (!done && !hung && line < STIM_LINES)
		begin
			base = line * STIM_COLS;
			op = int'(stim[base]);
			addr = stim[base + 1][7:0];
			data = stim[base + 2];
			strb = stim[base + 3][3:0];
			stall = int'(stim[base + 4]);
			exp_word = stim[base + 5];
			if (stall == RANDOM_STALL)
				stall = int'($urandom % 8);
			case (op)
			1: send_write(addr, data, strb, stall);
			2: send_read(addr, exp_word, stall);
			3: wait_reset_pulse();
			4: interrupt = data[0];
			5: wait_halted(data[0]);
			6:
			begin
				drain_responses();
				$display("Test %0d finished with %0d errors", data, errors - test_start);
				tests_run++;
				test_start = errors;
			end
			7: drain_responses();
			default: done = 1'b1;
			endcase
			line++;
		end

		if (tests_run == 0)
		begin
			$display("No tests were read from the stimulus file");
			errors++;
		end
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/zipdbg_stim.txt ====
// op addr data strb stall expect, all hex, stall ff draws a random count
// op 1 write, 2 read, 3 reset pulse, 4 interrupt, 5 halted level, 6 end test, 7 drain, 0 stop
3 00 00000000 0 00 00000000
2 00 00000000 0 00 00000400
6 00 00000001 0 00 00000000
1 8c 11223344 f 00 00000000
1 8c aabbccdd 5 02 00000000
1 80 0badf00d f 00 00000000
7 00 00000000 0 00 00000000
2 8c 00000000 0 01 11bb33dd
2 80 00000000 0 00 0badf00d
6 00 00000002 0 00 00000000
1 00 00000000 2 00 00000000
5 00 00000000 0 00 00000000
2 00 00000000 0 00 00000200
1 a0 cafef00d f 03 00000000
7 00 00000000 0 00 00000000
5 00 00000001 0 00 00000000
2 a0 00000000 0 00 cafef00d
2 00 00000000 0 00 00000400
6 00 00000003 0 00 00000000
1 00 00000100 2 00 00000000
7 00 00000000 0 00 00000000
2 00 00000000 0 00 00000400
6 00 00000004 0 00 00000000
1 00 00000040 1 00 00000000
3 00 00000000 0 00 00000000
4 00 00000001 0 00 00000000
2 00 00000000 0 00 00000480
6 00 00000005 0 00 00000000
1 84 01010101 f ff 00000000
1 88 02020202 f ff 00000000
1 8c 03030303 f ff 00000000
1 84 04040404 3 ff 00000000
7 00 00000000 0 00 00000000
2 84 00000000 0 ff 01010404
2 88 00000000 0 ff 02020202
2 8c 00000000 0 ff 03030303
2 00 00000000 0 ff 00000480
2 84 00000000 0 ff 01010404
6 00 00000006 0 00 00000000
0 00 00000000 0 00 00000000

// ==== verilog/cpu_control.sv ====
////////////////////////////////////////////////////////////
// Reset hold, halt and step control of the CPU.
// Halt and step need the byte 1 strobe, reset needs byte 0.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "zipdbg_macros.svh"

module cpu_control
	import zipdbg_pkg::*;
(
	input  wire		S_AXI_ACLK,
	input  wire		S_AXI_ARESETN,
	input  wire		i_cpu_reset,
	input  wire		i_interrupt,
	input  dbg_wreq_t	i_wreq,
	output logic		o_halted,
	output dbg_word_t	o_status,
	output logic		o_cmd_reset
);

	localparam int CNT_W = $clog2(`ZD_RESET_DURATION + 1);

	logic [CNT_W-1:0]	rst_count;
	ctrl_state_t		state;
	logic			cmd_write, reg_write;
	logic			reset_cmd, step_cmd, halt_cmd, run_cmd;
	logic			reset_next;
	logic			halt_pend;

	// Command decode
	assign cmd_write = i_wreq.valid && !i_wreq.is_reg;
	assign reg_write = i_wreq.valid && i_wreq.is_reg;
	assign reset_cmd = cmd_write && i_wreq.strb[0] && i_wreq.data[`ZD_RESET_BIT];
	assign step_cmd  = cmd_write && i_wreq.strb[1] && i_wreq.data[`ZD_STEP_BIT];
	assign halt_cmd  = cmd_write && i_wreq.strb[1] && i_wreq.data[`ZD_HALT_BIT]
			&& !i_wreq.data[`ZD_STEP_BIT];
	assign run_cmd   = cmd_write && i_wreq.strb[1] && !i_wreq.data[`ZD_HALT_BIT]
			&& !i_wreq.data[`ZD_STEP_BIT];

	////////////////////////////////////////////////////////////
	// Power-up reset hold
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			rst_count <= CNT_W'(`ZD_RESET_DURATION);
		else if (rst_count != 0)
			rst_count <= rst_count - 1'b1;
	end

	// Hold covers the full count, a command adds one cycle
	assign reset_next = (rst_count > 1) || reset_cmd;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= reset_next;
	end

	// Register write seen before the CPU could halt
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || state == CTRL_HALTED)
			halt_pend <= 1'b0;
		else if (reg_write)
			halt_pend <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			state <= CTRL_RESET;
		else if (reset_next)
			state <= CTRL_RESET;
		else
		begin
			case (state)
			CTRL_RESET:
				if (`ZD_START_HALTED || halt_pend || reg_write)
					state <= CTRL_HALTED;
				else
					state <= CTRL_RUNNING;
			CTRL_HALTED:
				if (step_cmd)
					state <= CTRL_STEP;
				else if (run_cmd)
					state <= CTRL_RUNNING;
			CTRL_RUNNING:
				if (halt_cmd || reg_write)
					state <= CTRL_HALTED;
				else if (step_cmd)
					state <= CTRL_STEP;
			// A single step always ends halted
			default:
				state <= CTRL_HALTED;
			endcase
		end
	end

	assign o_halted = (state == CTRL_HALTED);

	// Status word, unused bits read as zero
	always_comb
	begin
		o_status = '0;
		o_status[`ZD_ST_INT_BIT]  = i_interrupt;
		o_status[`ZD_RESET_BIT]   = o_cmd_reset;
		o_status[`ZD_ST_RUN_BIT]  = !o_halted;
		o_status[`ZD_ST_HALT_BIT] = o_halted;
	end

	a_reset_state: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_cmd_reset |-> (state == CTRL_RESET))
		else $error("CPU reset outside of the reset state");

endmodule

`default_nettype wire

// ==== verilog/dbg_regfile.sv ====
////////////////////////////////////////////////////////////
// Debug view of the 32 CPU registers, no reset on contents.
// Writes land only while the CPU is halted.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "zipdbg_macros.svh"

module dbg_regfile
	import zipdbg_pkg::*;
(
	input  wire		S_AXI_ACLK,
	input  wire		S_AXI_ARESETN,
	input  dbg_wreq_t	i_wreq,
	input  dbg_rreq_t	i_rreq,
	input  wire		i_halted,
	output logic		o_wr_stall,
	output dbg_word_t	o_rdata,
	output logic		o_rvalid
);

	dbg_word_t	bank [`ZD_NREGS];
	logic		pend_valid;
	dbg_ridx_t	pend_idx;
	dbg_word_t	pend_data;
	dbg_strb_t	pend_strb;
	logic		reg_wr, rd_reg;

	// Byte lanes of new_w replace old_w under the strobe
	function automatic dbg_word_t merge_bytes(input dbg_word_t old_w,
			input dbg_word_t new_w, input dbg_strb_t strb);
		dbg_word_t res;
		res = old_w;
		for (int b = 0; b < $bits(dbg_strb_t); b++)
		begin
			if (strb[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	assign reg_wr = i_wreq.valid && i_wreq.is_reg;
	assign rd_reg = i_rreq.valid && i_rreq.is_reg;

	// Pending write, retires on the first halted cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			pend_valid <= 1'b0;
		else if (reg_wr)
			pend_valid <= 1'b1;
		else if (i_halted)
			pend_valid <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (reg_wr)
		begin
			pend_idx  <= i_wreq.idx;
			pend_data <= i_wreq.data;
			pend_strb <= i_wreq.strb;
		end
	end

	assign o_wr_stall = pend_valid && !i_halted;

	// Bank update
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (pend_valid && i_halted)
			bank[pend_idx] <= merge_bytes(bank[pend_idx], pend_data, pend_strb);
	end

	////////////////////////////////////////////////////////////
	// Read port, one cycle latency
	////////////////////////////////////////////////////////////
	// Pending data is forwarded so a read never sees stale bytes
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_reg)
		begin
			if (pend_valid && pend_idx == i_rreq.idx)
				o_rdata <= merge_bytes(bank[i_rreq.idx], pend_data, pend_strb);
			else
				o_rdata <= bank[i_rreq.idx];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else
			o_rvalid <= rd_reg;
	end

endmodule

`default_nettype wire

// ==== verilog/dbg_request.sv ====
////////////////////////////////////////////////////////////
// AXI-lite request stage, one write and one read per cycle.
// PROT and the byte offset of the address are ignored.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "zipdbg_macros.svh"

module dbg_request
	import zipdbg_pkg::*;
(
	input  wire			S_AXI_ACLK,
	input  wire			S_AXI_ARESETN,
	// Write address
	input  wire			S_DBG_AWVALID,
	output logic			S_DBG_AWREADY,
	input  wire [`ZD_ADDR_W-1:0]	S_DBG_AWADDR,
	input  wire [2:0]		S_DBG_AWPROT,
	// Write data
	input  wire			S_DBG_WVALID,
	output logic			S_DBG_WREADY,
	input  dbg_word_t		S_DBG_WDATA,
	input  dbg_strb_t		S_DBG_WSTRB,
	// Read address
	input  wire			S_DBG_ARVALID,
	output logic			S_DBG_ARREADY,
	input  wire [`ZD_ADDR_W-1:0]	S_DBG_ARADDR,
	input  wire [2:0]		S_DBG_ARPROT,
	// Back-pressure from the bank and the response stage
	input  wire			i_wr_stall,
	input  wire			i_rsp_wfree,
	input  wire			i_rsp_rfree,
	output dbg_wreq_t		o_wreq,
	output dbg_rreq_t		o_rreq
);

	localparam int AW = $bits(dbg_waddr_t);
	localparam int WW = $bits(dbg_word_t) + $bits(dbg_strb_t);

	logic		aw_valid, w_valid, ar_valid;
	dbg_waddr_t	aw_addr, ar_addr;
	logic [WW-1:0]	w_bus;
	logic		wr_accept, rd_accept;
	logic		rd_inflight;

	////////////////////////////////////////////////////////////
	// Channel skids
	////////////////////////////////////////////////////////////
	dbg_skid #(.DW(AW)) u_awskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[`ZD_ADDR_W-1:2]),
		.o_valid(aw_valid), .i_ready(wr_accept), .o_data(aw_addr)
	);

	dbg_skid #(.DW(WW)) u_wskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({ S_DBG_WDATA, S_DBG_WSTRB }),
		.o_valid(w_valid), .i_ready(wr_accept), .o_data(w_bus)
	);

	dbg_skid #(.DW(AW)) u_arskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[`ZD_ADDR_W-1:2]),
		.o_valid(ar_valid), .i_ready(rd_accept), .o_data(ar_addr)
	);

	////////////////////////////////////////////////////////////
	// Acceptance
	////////////////////////////////////////////////////////////
	// Address bit 5 picks the register bank
	assign wr_accept = aw_valid && w_valid && i_rsp_wfree
			&& !(aw_addr[5] && i_wr_stall);

	// One register read at a time, R must be able to take it
	assign rd_accept = ar_valid && !rd_inflight && i_rsp_rfree;

	// Bank data comes back on the next cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_inflight <= 1'b0;
		else
			rd_inflight <= rd_accept && ar_addr[5];
	end

	// Request pulses
	always_comb
	begin
		o_wreq.valid  = wr_accept;
		o_wreq.is_reg = aw_addr[5];
		o_wreq.idx    = aw_addr[4:0];
		o_wreq.data   = w_bus[WW-1:$bits(dbg_strb_t)];
		o_wreq.strb   = w_bus[$bits(dbg_strb_t)-1:0];
		o_rreq.valid  = rd_accept;
		o_rreq.is_reg = ar_addr[5];
		o_rreq.idx    = ar_addr[4:0];
	end

endmodule

`default_nettype wire

// ==== verilog/dbg_response.sv ====
////////////////////////////////////////////////////////////
// B and R channels of the debug port, always OKAY.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dbg_response
	import zipdbg_pkg::*;
(
	input  wire		S_AXI_ACLK,
	input  wire		S_AXI_ARESETN,
	input  dbg_wreq_t	i_wreq,
	input  dbg_rreq_t	i_rreq,
	input  dbg_word_t	i_status,
	input  dbg_word_t	i_rdata,
	input  wire		i_rvalid,
	output logic		o_wfree,
	output logic		o_rfree,
	// Write response
	output logic		S_DBG_BVALID,
	input  wire		S_DBG_BREADY,
	output logic [1:0]	S_DBG_BRESP,
	// Read response
	output logic		S_DBG_RVALID,
	input  wire		S_DBG_RREADY,
	output dbg_word_t	S_DBG_RDATA,
	output logic [1:0]	S_DBG_RRESP
);

	logic	load_status;

	assign o_wfree = !S_DBG_BVALID || S_DBG_BREADY;
	assign o_rfree = !S_DBG_RVALID || S_DBG_RREADY;

	// Status reads answer at once, bank reads via i_rvalid
	assign load_status = i_rreq.valid && !i_rreq.is_reg;

	// Write response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_BVALID <= 1'b0;
		else if (i_wreq.valid)
			S_DBG_BVALID <= 1'b1;
		else if (S_DBG_BREADY)
			S_DBG_BVALID <= 1'b0;
	end

	// Read response valid
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_RVALID <= 1'b0;
		else if (o_rfree)
			S_DBG_RVALID <= load_status || i_rvalid;
	end

	// Read data
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rfree && (load_status || i_rvalid))
			S_DBG_RDATA <= i_rvalid ? i_rdata : i_status;
	end

	assign S_DBG_BRESP = 2'b00;
	assign S_DBG_RRESP = 2'b00;

	// Request stage and bank must never overrun a stalled R
	a_no_overrun: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_DBG_RVALID && !S_DBG_RREADY) |-> !(load_status || i_rvalid))
		else $error("read response loaded while R was stalled");

endmodule

`default_nettype wire

// ==== verilog/dbg_skid.sv ====
////////////////////////////////////////////////////////////
// One-deep skid buffer, output not registered.
// Upstream ready comes straight from a flop.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dbg_skid #(
	parameter int DW = 8
) (
	input  wire		S_AXI_ACLK,
	input  wire		S_AXI_ARESETN,
	// Upstream side
	input  wire		i_valid,
	output logic		o_ready,
	input  wire [DW-1:0]	i_data,
	// Downstream side
	output logic		o_valid,
	input  wire		i_ready,
	output logic [DW-1:0]	o_data
);

	logic		r_valid;
	logic [DW-1:0]	r_data;

	// Capture when upstream hands off and downstream stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Held item, loaded whenever the buffer is empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	assign o_ready = !r_valid;
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

	// Stalled output keeps its value across the edge
	a_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_data)))
		else $error("skid output changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/zipdbg_macros.svh ====
////////////////////////////////////////////////////////////
// Widths and bit positions of the AXI-lite debug port.
// The debug data path is fixed at 32 bits.
////////////////////////////////////////////////////////////
`ifndef ZIPDBG_MACROS_SVH
`define ZIPDBG_MACROS_SVH

// Bus widths
`define ZD_ADDR_W		8
`define ZD_DATA_W		32
`define ZD_NREGS		32

// Command word bits
`define ZD_RESET_BIT		6
`define ZD_STEP_BIT		8
`define ZD_HALT_BIT		10

// Status word bits
`define ZD_ST_INT_BIT		7
`define ZD_ST_RUN_BIT		9
`define ZD_ST_HALT_BIT		10

// Power-up behavior
`define ZD_RESET_DURATION	10
`define ZD_START_HALTED		1

`endif

// ==== verilog/zipdbg_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the debug port.
// Widths here must agree with the macros header.
////////////////////////////////////////////////////////////
`default_nettype none

package zipdbg_pkg;

	// Plain vectors with a meaning
	typedef logic [31:0]	dbg_word_t;
	typedef logic [3:0]	dbg_strb_t;
	typedef logic [5:0]	dbg_waddr_t;
	typedef logic [4:0]	dbg_ridx_t;

	// One accepted write, register or command
	typedef struct packed {
		logic		valid;
		logic		is_reg;
		dbg_ridx_t	idx;
		dbg_word_t	data;
		dbg_strb_t	strb;
	} dbg_wreq_t;

	// One accepted read, register or status
	typedef struct packed {
		logic		valid;
		logic		is_reg;
		dbg_ridx_t	idx;
	} dbg_rreq_t;

	// CPU control states
	typedef enum logic [1:0] {
		CTRL_RESET,
		CTRL_HALTED,
		CTRL_RUNNING,
		CTRL_STEP
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/zipdbg_top.sv ====
////////////////////////////////////////////////////////////
// Debug side of the CPU wrapper, 8-bit AXI-lite address.
// Bit 5 of the word address selects the register bank.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zipdbg_top
	import zipdbg_pkg::*;
(
	input  wire		S_AXI_ACLK,
	input  wire		S_AXI_ARESETN,
	input  wire		i_interrupt,
	input  wire		i_cpu_reset,
	// Write address
	input  wire		S_DBG_AWVALID,
	output logic		S_DBG_AWREADY,
	input  wire [7:0]	S_DBG_AWADDR,
	input  wire [2:0]	S_DBG_AWPROT,
	// Write data
	input  wire		S_DBG_WVALID,
	output logic		S_DBG_WREADY,
	input  dbg_word_t	S_DBG_WDATA,
	input  dbg_strb_t	S_DBG_WSTRB,
	// Write response
	output logic		S_DBG_BVALID,
	input  wire		S_DBG_BREADY,
	output logic [1:0]	S_DBG_BRESP,
	// Read address
	input  wire		S_DBG_ARVALID,
	output logic		S_DBG_ARREADY,
	input  wire [7:0]	S_DBG_ARADDR,
	input  wire [2:0]	S_DBG_ARPROT,
	// Read response
	output logic		S_DBG_RVALID,
	input  wire		S_DBG_RREADY,
	output dbg_word_t	S_DBG_RDATA,
	output logic [1:0]	S_DBG_RRESP,
	// CPU control
	output logic		o_cmd_reset,
	output logic		o_halted
);

	dbg_wreq_t	wreq;
	dbg_rreq_t	rreq;
	dbg_word_t	status, reg_rdata;
	logic		wr_stall, reg_rvalid;
	logic		rsp_wfree, rsp_rfree;

	dbg_request u_request (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_DBG_AWVALID(S_DBG_AWVALID), .S_DBG_AWREADY(S_DBG_AWREADY),
		.S_DBG_AWADDR(S_DBG_AWADDR), .S_DBG_AWPROT(S_DBG_AWPROT),
		.S_DBG_WVALID(S_DBG_WVALID), .S_DBG_WREADY(S_DBG_WREADY),
		.S_DBG_WDATA(S_DBG_WDATA), .S_DBG_WSTRB(S_DBG_WSTRB),
		.S_DBG_ARVALID(S_DBG_ARVALID), .S_DBG_ARREADY(S_DBG_ARREADY),
		.S_DBG_ARADDR(S_DBG_ARADDR), .S_DBG_ARPROT(S_DBG_ARPROT),
		.i_wr_stall(wr_stall), .i_rsp_wfree(rsp_wfree), .i_rsp_rfree(rsp_rfree),
		.o_wreq(wreq), .o_rreq(rreq)
	);

	cpu_control u_control (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset), .i_interrupt(i_interrupt),
		.i_wreq(wreq), .o_halted(o_halted),
		.o_status(status), .o_cmd_reset(o_cmd_reset)
	);

	// Bank follows the halted level straight from the FSM
	dbg_regfile u_regfile (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wreq(wreq), .i_rreq(rreq), .i_halted(o_halted),
		.o_wr_stall(wr_stall), .o_rdata(reg_rdata), .o_rvalid(reg_rvalid)
	);

	dbg_response u_response (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wreq(wreq), .i_rreq(rreq), .i_status(status),
		.i_rdata(reg_rdata), .i_rvalid(reg_rvalid),
		.o_wfree(rsp_wfree), .o_rfree(rsp_rfree),
		.S_DBG_BVALID(S_DBG_BVALID), .S_DBG_BREADY(S_DBG_BREADY),
		.S_DBG_BRESP(S_DBG_BRESP),
		.S_DBG_RVALID(S_DBG_RVALID), .S_DBG_RREADY(S_DBG_RREADY),
		.S_DBG_RDATA(S_DBG_RDATA), .S_DBG_RRESP(S_DBG_RRESP)
	);

endmodule

`default_nettype wire
